// File: include/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

//////////////////////////////
// Widths
//////////////////////////////

`define FETCH_XLEN 32            // Address and instruction width.
`define FETCH_BLOCK_BITS 128     // Cache line and memory transfer.

//////////////////////////////
// Sizes
//////////////////////////////

`define FETCH_CACHE_LINES 16
`define FETCH_BTB_ENTRIES 16

// Bubble word, ADDI x0,x0,0.
`define FETCH_NOP 32'h0000_0013

`endif

// File: source/fetch_pkg.sv
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    // Major opcodes seen by the predecode.
    typedef enum logic [1:0] {
        OPC_BRANCH,
        OPC_JAL,
        OPC_JALR,
        OPC_OTHER
    } opcode_e;

    typedef enum logic [1:0] {
        REFILL_IDLE,
        REFILL_REQUEST,
        REFILL_WAIT,
        REFILL_WRITE
    } refill_state_e;

    //////////////////////////////
    // Memory side
    //////////////////////////////

    typedef struct packed {
        logic                         valid;
        logic [`FETCH_XLEN-1:0]       addr;     // Block aligned.
    } mem_req_t;

    typedef struct packed {
        logic                         available;
        logic                         valid;
        logic [`FETCH_BLOCK_BITS-1:0] block;
    } mem_rsp_t;

    //////////////////////////////
    // Core side
    //////////////////////////////

    typedef struct packed {
        logic                         valid;
        logic [`FETCH_XLEN-1:0]       target;
    } redirect_t;

    typedef struct packed {
        logic                         valid;
        logic                         taken;
        logic [`FETCH_XLEN-1:0]       pc;       // Address of the branch.
        logic [`FETCH_XLEN-1:0]       target;
    } update_t;

    typedef struct packed {
        logic                         taken;
        logic [`FETCH_XLEN-1:0]       target;
    } prediction_t;

    typedef struct packed {
        logic                         valid;
        logic [`FETCH_XLEN-1:0]       pc;
        logic [`FETCH_XLEN-1:0]       instr;
        logic                         predicted_taken;
    } fetch_out_t;

endpackage

`default_nettype wire

// File: source/pc_generator.sv
`default_nettype none

`include "fetch_macros.svh"

module pc_generator (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   stall_i,
    input  wire logic                   miss_i,
    input  wire fetch_pkg::redirect_t   redirect_i,
    input  wire fetch_pkg::prediction_t prediction_i,
    output logic [`FETCH_XLEN-1:0]      pc_o
);

    localparam logic [`FETCH_XLEN-1:0] RESET_VECTOR = '0;
    localparam logic [`FETCH_XLEN-1:0] PC_STEP      = 4;

    logic [`FETCH_XLEN-1:0] pc_q;
    logic [`FETCH_XLEN-1:0] pc_next;
    logic                   hold;

    // Decode back-pressure or an open refill keeps the current address.
    assign hold = stall_i | miss_i;

    //////////////////////////////
    // Next address select
    //////////////////////////////

    always_comb begin
        if (redirect_i.valid) begin
            pc_next = redirect_i.target;        // Execute wins over everything.
        end else if (hold) begin
            pc_next = pc_q;
        end else if (prediction_i.taken) begin
            pc_next = prediction_i.target;
        end else begin
            pc_next = pc_q + PC_STEP;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_VECTOR;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: source/icache_array.sv
`default_nettype none

`include "fetch_macros.svh"

module icache_array (
    input  wire logic                         clk_i,
    input  wire logic                         rst_n_i,
    input  wire logic [`FETCH_XLEN-1:0]       pc_i,
    input  wire logic                         write_i,
    input  wire logic [`FETCH_XLEN-1:0]       write_addr_i,
    input  wire logic [`FETCH_BLOCK_BITS-1:0] block_i,
    output logic                              hit_o,
    output logic [`FETCH_XLEN-1:0]            instr_o
);

    localparam int WORDS       = `FETCH_BLOCK_BITS / `FETCH_XLEN;
    localparam int WORD_BITS   = $clog2(WORDS);
    localparam int OFFSET_BITS = $clog2(`FETCH_BLOCK_BITS / 8);
    localparam int INDEX_BITS  = $clog2(`FETCH_CACHE_LINES);
    localparam int TAG_BITS    = `FETCH_XLEN - INDEX_BITS - OFFSET_BITS;

    logic [`FETCH_CACHE_LINES-1:0] valid_q;
    logic [TAG_BITS-1:0]           tag_q  [`FETCH_CACHE_LINES];
    logic [`FETCH_BLOCK_BITS-1:0]  data_q [`FETCH_CACHE_LINES];

    logic [WORD_BITS-1:0]          rd_word;
    logic [INDEX_BITS-1:0]         rd_index;
    logic [TAG_BITS-1:0]           rd_tag;
    logic [INDEX_BITS-1:0]         wr_index;
    logic [WORDS-1:0][`FETCH_XLEN-1:0] rd_line;

    // Address split.
    assign rd_word  = pc_i[OFFSET_BITS-1:2];
    assign rd_index = pc_i[OFFSET_BITS +: INDEX_BITS];
    assign rd_tag   = pc_i[`FETCH_XLEN-1 -: TAG_BITS];
    assign wr_index = write_addr_i[OFFSET_BITS +: INDEX_BITS];

    // Same-cycle lookup, word 0 in the low bits of the block.
    assign rd_line = data_q[rd_index];
    assign hit_o   = valid_q[rd_index] && (tag_q[rd_index] == rd_tag);
    assign instr_o = rd_line[rd_word];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (write_i) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_i) begin
            tag_q[wr_index]  <= write_addr_i[`FETCH_XLEN-1 -: TAG_BITS];
            data_q[wr_index] <= block_i;
        end
    end

endmodule

`default_nettype wire

// File: source/icache_refill.sv
`default_nettype none

`include "fetch_macros.svh"

module icache_refill (
    input  wire logic                         clk_i,
    input  wire logic                         rst_n_i,
    input  wire logic [`FETCH_XLEN-1:0]       pc_i,
    input  wire logic                         hit_i,
    input  wire logic                         redirect_valid_i,
    output fetch_pkg::mem_req_t               mem_req_o,
    input  wire fetch_pkg::mem_rsp_t          mem_rsp_i,
    output logic                              write_o,
    output logic [`FETCH_XLEN-1:0]            write_addr_o,
    output logic [`FETCH_BLOCK_BITS-1:0]      block_o,
    output logic                              miss_o
);

    localparam int OFFSET_BITS = $clog2(`FETCH_BLOCK_BITS / 8);

    fetch_pkg::refill_state_e       state_q;
    fetch_pkg::refill_state_e       state_next;
    logic [`FETCH_XLEN-1:0]         req_addr_q;
    logic [`FETCH_BLOCK_BITS-1:0]   block_q;
    logic                           miss_seen;
    logic                           issue;

    assign miss_seen = (state_q == fetch_pkg::REFILL_IDLE) && !hit_i;

    // A request not yet issued is dropped when execute redirects.
    assign issue = (state_q == fetch_pkg::REFILL_REQUEST) && mem_rsp_i.available
                   && !redirect_valid_i;

    //////////////////////////////
    // Refill FSM
    //////////////////////////////

    always_comb begin
        state_next = state_q;
        case (state_q)
            fetch_pkg::REFILL_IDLE: begin
                if (miss_seen && !redirect_valid_i) begin
                    state_next = fetch_pkg::REFILL_REQUEST;
                end
            end
            fetch_pkg::REFILL_REQUEST: begin
                if (redirect_valid_i) begin
                    state_next = fetch_pkg::REFILL_IDLE;
                end else if (issue) begin
                    state_next = fetch_pkg::REFILL_WAIT;
                end
            end
            fetch_pkg::REFILL_WAIT: begin
                if (mem_rsp_i.valid) state_next = fetch_pkg::REFILL_WRITE;
            end
            default: state_next = fetch_pkg::REFILL_IDLE;   // One write cycle.
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= fetch_pkg::REFILL_IDLE;
        end else begin
            state_q <= state_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (miss_seen) begin
            req_addr_q <= {pc_i[`FETCH_XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        end
        if ((state_q == fetch_pkg::REFILL_WAIT) && mem_rsp_i.valid) begin
            block_q <= mem_rsp_i.block;
        end
    end

    // Request stays up unchanged until the block comes back.
    assign mem_req_o.valid = issue || (state_q == fetch_pkg::REFILL_WAIT);
    assign mem_req_o.addr  = req_addr_q;

    assign write_o      = (state_q == fetch_pkg::REFILL_WRITE);
    assign write_addr_o = req_addr_q;
    assign block_o      = block_q;
    assign miss_o       = miss_seen || (state_q != fetch_pkg::REFILL_IDLE);

endmodule

`default_nettype wire

// File: source/branch_predictor.sv
`default_nettype none

`include "fetch_macros.svh"

module branch_predictor (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire logic [`FETCH_XLEN-1:0] pc_i,
    input  wire logic [`FETCH_XLEN-1:0] instr_i,
    input  wire logic                   hit_i,
    input  wire fetch_pkg::update_t     update_i,
    output fetch_pkg::prediction_t      prediction_o
);

    localparam int IDX_BITS = $clog2(`FETCH_BTB_ENTRIES);
    localparam int TAG_BITS = `FETCH_XLEN - IDX_BITS - 2;

    fetch_pkg::opcode_e           opcode;
    logic                         is_jump;

    logic [`FETCH_BTB_ENTRIES-1:0] valid_q;
    logic [1:0]                   ctr_q    [`FETCH_BTB_ENTRIES];
    logic [TAG_BITS-1:0]          tag_q    [`FETCH_BTB_ENTRIES];
    logic [`FETCH_XLEN-1:0]       target_q [`FETCH_BTB_ENTRIES];

    logic [IDX_BITS-1:0]          rd_idx;
    logic [TAG_BITS-1:0]          rd_tag;
    logic [IDX_BITS-1:0]          wr_idx;
    logic [TAG_BITS-1:0]          wr_tag;
    logic                         rd_match;
    logic                         wr_match;

    //////////////////////////////
    // Predecode
    //////////////////////////////

    always_comb begin
        case (instr_i[6:0])
            7'b1100011: opcode = fetch_pkg::OPC_BRANCH;
            7'b1101111: opcode = fetch_pkg::OPC_JAL;
            7'b1100111: opcode = fetch_pkg::OPC_JALR;
            default:    opcode = fetch_pkg::OPC_OTHER;
        endcase
    end

    // JALR targets come from a register, so they are left to execute.
    assign is_jump = (opcode == fetch_pkg::OPC_BRANCH) || (opcode == fetch_pkg::OPC_JAL);

    assign rd_idx   = pc_i[2 +: IDX_BITS];
    assign rd_tag   = pc_i[`FETCH_XLEN-1 -: TAG_BITS];
    assign wr_idx   = update_i.pc[2 +: IDX_BITS];
    assign wr_tag   = update_i.pc[`FETCH_XLEN-1 -: TAG_BITS];
    assign rd_match = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign wr_match = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

    assign prediction_o.taken  = hit_i && is_jump && rd_match && ctr_q[rd_idx][1];
    assign prediction_o.target = target_q[rd_idx];

    //////////////////////////////
    // Training
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            for (int i = 0; i < `FETCH_BTB_ENTRIES; i++) begin
                ctr_q[i] <= 2'd0;
            end
        end else if (update_i.valid) begin
            valid_q[wr_idx] <= 1'b1;
            if (!wr_match) begin
                ctr_q[wr_idx] <= update_i.taken ? 2'd2 : 2'd1;     // Fresh entry.
            end else if (update_i.taken && (ctr_q[wr_idx] != 2'd3)) begin
                ctr_q[wr_idx] <= ctr_q[wr_idx] + 2'd1;
            end else if (!update_i.taken && (ctr_q[wr_idx] != 2'd0)) begin
                ctr_q[wr_idx] <= ctr_q[wr_idx] - 2'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_i.valid) begin
            tag_q[wr_idx] <= wr_tag;
            if (!wr_match || update_i.taken) target_q[wr_idx] <= update_i.target;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_stage (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire logic                 stall_i,
    input  wire fetch_pkg::redirect_t redirect_i,
    input  wire fetch_pkg::update_t   update_i,
    output fetch_pkg::mem_req_t       mem_req_o,
    input  wire fetch_pkg::mem_rsp_t  mem_rsp_i,
    output fetch_pkg::fetch_out_t     fetch_o
);

    logic [`FETCH_XLEN-1:0]       pc_w;
    logic                         hit_w;
    logic [`FETCH_XLEN-1:0]       instr_w;
    logic                         miss_w;
    logic                         write_w;
    logic [`FETCH_XLEN-1:0]       write_addr_w;
    logic [`FETCH_BLOCK_BITS-1:0] block_w;
    fetch_pkg::prediction_t       prediction_w;
    fetch_pkg::fetch_out_t        fetch_q;

    //////////////////////////////
    // Fetch steps
    //////////////////////////////

    pc_generator pc_gen_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .miss_i       (miss_w),
        .redirect_i   (redirect_i),
        .prediction_i (prediction_w),
        .pc_o         (pc_w)
    );

    icache_array icache_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .pc_i         (pc_w),
        .write_i      (write_w),
        .write_addr_i (write_addr_w),
        .block_i      (block_w),
        .hit_o        (hit_w),
        .instr_o      (instr_w)
    );

    icache_refill refill_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .pc_i             (pc_w),
        .hit_i            (hit_w),
        .redirect_valid_i (redirect_i.valid),
        .mem_req_o        (mem_req_o),
        .mem_rsp_i        (mem_rsp_i),
        .write_o          (write_w),
        .write_addr_o     (write_addr_w),
        .block_o          (block_w),
        .miss_o           (miss_w)
    );

    branch_predictor bpred_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .pc_i         (pc_w),
        .instr_i      (instr_w),
        .hit_i        (hit_w),
        .update_i     (update_i),
        .prediction_o (prediction_w)
    );

    //////////////////////////////
    // Output register
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fetch_q <= '{valid: 1'b0, pc: '0, instr: `FETCH_NOP, predicted_taken: 1'b0};
        end else if (redirect_i.valid) begin
            fetch_q <= '{valid: 1'b0, pc: pc_w, instr: `FETCH_NOP, predicted_taken: 1'b0};
        end else if (stall_i) begin
            fetch_q <= fetch_q;                 // Decode not ready.
        end else if (miss_w) begin
            fetch_q <= '{valid: 1'b0, pc: pc_w, instr: `FETCH_NOP, predicted_taken: 1'b0};
        end else begin
            fetch_q <= '{valid: 1'b1, pc: pc_w, instr: instr_w,
                         predicted_taken: prediction_w.taken};
        end
    end

    assign fetch_o = fetch_q;

endmodule

`default_nettype wire

// File: tests/fetch_memory_model.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_memory_model (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire fetch_pkg::mem_req_t req_i,
    output fetch_pkg::mem_rsp_t      rsp_o,
    output int                       request_count_o
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0]            lcg_state;
    logic                   busy;
    int                     wait_cnt;
    logic [`FETCH_XLEN-1:0] addr_q;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // BEQ x0,x0 at word 15 of every 64 byte span, ADDI x1,x0,A[13:2] elsewhere.
    function automatic logic [31:0] word_at(input logic [31:0] a);
        if (a[5:2] == 4'hf) begin
            return 32'h0000_0063;
        end
        return {a[13:2], 5'd0, 3'b000, 5'd1, 7'b0010011};
    endfunction

    function automatic logic [`FETCH_BLOCK_BITS-1:0] build_block(input logic [31:0] a);
        logic [`FETCH_BLOCK_BITS-1:0] blk;
        blk = '0;
        for (int i = 0; i < 4; i++) begin
            blk[i*32 +: 32] = word_at(a + 32'(4 * i));
        end
        return blk;
    endfunction

    initial begin
        lcg_state = 32'hac1d;
        busy = 1'b0;
        wait_cnt = 0;
        addr_q = '0;
        request_count_o = 0;
        rsp_o = '{available: 1'b1, valid: 1'b0, block: '0};
    end

    // Accepts on the edge where the stage holds a request up.
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy = 1'b0;
        end else if (!busy && req_i.valid) begin
            busy = 1'b1;
            addr_q = req_i.addr;
            wait_cnt = 1 + int'((lcg_next() >> 16) % 6);   // 1 to 6 cycles.
            request_count_o++;
        end else if (busy && rsp_o.valid) begin
            busy = 1'b0;
        end
    end

    always @(negedge clk_i) begin
        rsp_o.valid = 1'b0;
        if (!rst_n_i) begin
            rsp_o.available = 1'b1;
        end else if (busy) begin
            rsp_o.available = 1'b1;
            wait_cnt--;
            if (wait_cnt == 0) begin
                rsp_o.valid = 1'b1;
                rsp_o.block = build_block(addr_q);
            end
        end else begin
            rsp_o.available = ((lcg_next() >> 16) % 8) != 0;   // Busy now and then.
        end
    end

endmodule

`default_nettype wire

// File: tests/fetch_tb.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {ROW_RUN, ROW_REDIRECT, ROW_TRAIN, ROW_STALL} row_kind_e;

    typedef struct packed {
        row_kind_e   kind;
        logic [31:0] addr;
        logic [31:0] target;
        logic        taken;
        logic [15:0] count;     // Valid outputs for a run, cycles for a stall.
    } row_t;

    localparam int NUM_ROWS = 14;
    localparam logic [31:0] BRANCH_PC = 32'h7c;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  stall_i;
    fetch_pkg::redirect_t  redirect_i;
    fetch_pkg::update_t    update_i;
    fetch_pkg::mem_req_t   mem_req;
    fetch_pkg::mem_rsp_t   mem_rsp;
    fetch_pkg::fetch_out_t fetch_o;
    int                    request_count;

    row_t                  rows [NUM_ROWS];
    int                    cycle_count;
    int                    cycle_limit;
    int                    valid_seen;
    int                    requests_seen;
    int                    taken_seen;
    int                    fallthrough_seen;

    // Reference state.
    logic [31:0]           exp_pc;
    logic                  prev_rst;
    logic                  prev_stall;
    logic                  prev_redirect;
    logic                  req_prev;
    fetch_pkg::mem_req_t   open_req;
    fetch_pkg::fetch_out_t last_out;
    fetch_pkg::update_t    pending;
    logic [15:0]           ref_valid;
    logic [31:0]           ref_pc     [16];
    logic [31:0]           ref_target [16];
    logic [1:0]            ref_ctr    [16];
    logic [15:0]           line_valid;
    logic [31:0]           line_addr  [16];

    fetch_stage dut_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall_i),
        .redirect_i (redirect_i),
        .update_i   (update_i),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp),
        .fetch_o    (fetch_o)
    );

    fetch_memory_model mem_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .req_i           (mem_req),
        .rsp_o           (mem_rsp),
        .request_count_o (request_count)
    );

    always #4 clk_i = ~clk_i;

    //////////////////////////////
    // Reference functions
    //////////////////////////////

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        if (a[5:2] == 4'hf) return 32'h0000_0063;     // BEQ x0,x0.
        return {a[13:2], 5'd0, 3'b000, 5'd1, 7'b0010011};
    endfunction

    function automatic logic ref_predict(input logic [31:0] pc);
        logic [3:0]  idx;
        logic [31:0] word;
        idx = pc[5:2];
        word = expected_word(pc);
        return (word[6:0] == 7'b1100011) && ref_valid[idx]
               && (ref_pc[idx] == pc) && ref_ctr[idx][1];
    endfunction

    task automatic ref_train(input fetch_pkg::update_t u);
        logic [3:0] idx;
        logic       match;
        idx = u.pc[5:2];
        match = ref_valid[idx] && (ref_pc[idx] == u.pc);
        if (!match) ref_ctr[idx] = u.taken ? 2'd2 : 2'd1;
        else if (u.taken && ref_ctr[idx] != 2'd3) ref_ctr[idx] = ref_ctr[idx] + 2'd1;
        else if (!u.taken && ref_ctr[idx] != 2'd0) ref_ctr[idx] = ref_ctr[idx] - 2'd1;
        if (!match || u.taken) ref_target[idx] = u.target;
        ref_valid[idx] = 1'b1;
        ref_pc[idx] = u.pc;
    endtask

    function automatic int test_length();
        int total;
        total = 8;                                      // Reset and tail.
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += (rows[r].count == 0) ? 1 : int'(rows[r].count);
            if (rows[r].kind == ROW_RUN) total += 8 * (int'(rows[r].count) / 4 + 3);
        end
        return total;
    endfunction

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "fetch_tb stopped");
    endtask

    task automatic check_fetch(input fetch_pkg::fetch_out_t exp, input fetch_pkg::fetch_out_t got,
                               input logic check_pc, input string what);
        if (got.valid !== exp.valid || got.instr !== exp.instr
                || got.predicted_taken !== exp.predicted_taken
                || (check_pc && got.pc !== exp.pc)) begin
            report_failure({$sformatf("mismatch at %0t: %s, expected v%b pc %h instr %h pt %b",
                                      $time, what, exp.valid, exp.pc, exp.instr,
                                      exp.predicted_taken),
                            $sformatf(", got v%b pc %h instr %h pt %b",
                                      got.valid, got.pc, got.instr, got.predicted_taken)});
        end
    endtask

    task automatic check_request(input fetch_pkg::mem_req_t exp, input fetch_pkg::mem_req_t got,
                                 input logic check_addr, input string what);
        if (got.valid !== exp.valid || (check_addr && got.addr !== exp.addr)) begin
            report_failure($sformatf("mismatch at %0t: %s, expected v%b addr %h, got v%b addr %h",
                $time, what, exp.valid, exp.addr, got.valid, got.addr));
        end
    endtask

    //////////////////////////////
    // Monitor
    //////////////////////////////

    always @(posedge clk_i) begin
        fetch_pkg::fetch_out_t bubble;
        fetch_pkg::fetch_out_t exp;
        logic [3:0]            li;
        bubble = '{valid: 1'b0, pc: '0, instr: `FETCH_NOP, predicted_taken: 1'b0};
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            report_failure($sformatf("timeout: no end of test after %0d cycles", cycle_limit));
        end
        if (!rst_n_i) begin
            if (prev_rst) begin
                check_fetch(bubble, fetch_o, 1'b0, "output during reset");
                check_request('0, mem_req, 1'b0, "request during reset");
            end
            prev_rst = 1'b1;
            prev_stall = 1'b0;
            prev_redirect = 1'b0;
            req_prev = 1'b0;
            exp_pc = '0;
            pending = '0;
            ref_valid = '0;
            line_valid = '0;
        end else begin
            if (prev_rst) begin
                check_request('0, mem_req, 1'b0, "request right after reset");
            end
            if (prev_stall) begin
                check_fetch(last_out, fetch_o, 1'b1, "output held under stall");
            end else if (fetch_o.valid && !prev_redirect) begin
                exp = '{valid: 1'b1, pc: exp_pc, instr: expected_word(exp_pc),
                        predicted_taken: ref_predict(exp_pc)};
                check_fetch(exp, fetch_o, 1'b1, "valid output");
                if (exp_pc == BRANCH_PC && exp.predicted_taken) taken_seen++;
                if (exp_pc == BRANCH_PC && !exp.predicted_taken && taken_seen > 0) begin
                    fallthrough_seen++;
                end
                valid_seen++;
                exp_pc = exp.predicted_taken ? ref_target[exp_pc[5:2]] : exp_pc + 32'd4;
            end else begin
                check_fetch(bubble, fetch_o, 1'b0, "bubble");
            end
            last_out = fetch_o;
            if (mem_req.valid && !req_prev) begin
                check_request('{valid: 1'b1, addr: {exp_pc[31:4], 4'b0}}, mem_req, 1'b1,
                              "block request");
                li = mem_req.addr[7:4];
                if (line_valid[li] && line_addr[li] == mem_req.addr) begin
                    report_failure($sformatf("line %h requested again while cached", mem_req.addr));
                end
                line_valid[li] = 1'b1;
                line_addr[li] = mem_req.addr;
                open_req = mem_req;
                requests_seen++;
            end else if (mem_req.valid) begin
                check_request(open_req, mem_req, 1'b1, "request held until response");
            end
            req_prev = mem_req.valid;
            if (pending.valid) ref_train(pending);
            pending = update_i;
            if (redirect_i.valid) exp_pc = redirect_i.target;
            prev_redirect = redirect_i.valid;
            prev_stall = stall_i && !redirect_i.valid;
            prev_rst = 1'b0;
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic apply_row(input row_t row);
        int goal;
        case (row.kind)
            ROW_RUN: begin
                goal = valid_seen + int'(row.count);
                while (valid_seen < goal) @(negedge clk_i);
            end
            ROW_STALL: begin
                stall_i = 1'b1;
                repeat (row.count) @(negedge clk_i);
                stall_i = 1'b0;
            end
            ROW_REDIRECT: begin
                redirect_i = '{valid: 1'b1, target: row.target};
                @(negedge clk_i);
                redirect_i = '0;
            end
            default: begin
                update_i = '{valid: 1'b1, taken: row.taken, pc: row.addr, target: row.target};
                @(negedge clk_i);
                update_i = '0;
            end
        endcase
    endtask

    initial begin
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        stall_i = 1'b0;
        redirect_i = '0;
        update_i = '0;
        cycle_count = 0;
        valid_seen = 0;
        requests_seen = 0;
        taken_seen = 0;
        fallthrough_seen = 0;
        prev_rst = 1'b0;
        rows[0]  = '{ROW_RUN,      32'h0,     32'h0,     1'b0, 16'd24};
        rows[1]  = '{ROW_STALL,    32'h0,     32'h0,     1'b0, 16'd5};
        rows[2]  = '{ROW_RUN,      32'h0,     32'h0,     1'b0, 16'd8};
        rows[3]  = '{ROW_REDIRECT, 32'h0,     32'h0,     1'b0, 16'd1};   // Back into a filled line.
        rows[4]  = '{ROW_RUN,      32'h0,     32'h0,     1'b0, 16'd6};
        rows[5]  = '{ROW_TRAIN,    BRANCH_PC, 32'h200,   1'b1, 16'd1};
        rows[6]  = '{ROW_REDIRECT, 32'h0,     32'h70,    1'b0, 16'd1};
        rows[7]  = '{ROW_RUN,      32'h0,     32'h0,     1'b0, 16'd8};
        rows[8]  = '{ROW_TRAIN,    BRANCH_PC, 32'h200,   1'b0, 16'd1};
        rows[9]  = '{ROW_TRAIN,    BRANCH_PC, 32'h200,   1'b0, 16'd1};
        rows[10] = '{ROW_REDIRECT, 32'h0,     32'h74,    1'b0, 16'd1};
        rows[11] = '{ROW_RUN,      32'h0,     32'h0,     1'b0, 16'd6};
        rows[12] = '{ROW_STALL,    32'h0,     32'h0,     1'b0, 16'd3};
        rows[13] = '{ROW_RUN,      32'h0,     32'h0,     1'b0, 16'd4};
        cycle_limit = test_length();
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(rows[r]);
        end
        repeat (2) @(negedge clk_i);
        if (request_count != requests_seen) begin
            report_failure($sformatf("memory saw %0d requests, the stage issued %0d",
                                     request_count, requests_seen));
        end else if (taken_seen == 0 || fallthrough_seen == 0) begin
            report_failure("trained branch was not seen both taken and not taken");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
source/fetch_pkg.sv
source/pc_generator.sv
source/icache_array.sv
source/icache_refill.sv
source/branch_predictor.sv
source/fetch_stage.sv
tests/fetch_memory_model.sv
tests/fetch_tb.sv

// File: Makefile
# Verilator build and run of the fetch stage testbench.

SIM = obj_dir/Vfetch_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module fetch_tb -o Vfetch_tb

run: build
	-./$(SIM) 2>&1 | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only -Wall +incdir+include source/fetch_pkg.sv source/pc_generator.sv \
		source/icache_array.sv source/icache_refill.sv source/branch_predictor.sv \
		source/fetch_stage.sv --top-module fetch_stage

clean:
	rm -rf obj_dir sim.log
